/* common/dbg_params.svh */
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////

// data word and program counter
`define DBG_XLEN        32
// register file index
`define DBG_REG_AW      5
// memory word index
`define DBG_MEM_AW      15
// parser byte counter
`define DBG_CNT_W       3

////////////////////////////////////////////////////////////////////////////
// byte counts and special values
////////////////////////////////////////////////////////////////////////////

`define DBG_WORD_BYTES  4
`define DBG_ADDR_BYTES  2
// loading this value switches the breakpoint off
`define DBG_BP_OFF      32'hffff_ffff

`endif

/* common/dbg_pkg.sv */
package dbg_pkg;

    // low 3 bits of the first command byte
    typedef enum logic [2:0] {
        OP_RUN   = 3'd0,
        OP_RESET = 3'd1,
        OP_PRINT = 3'd2,
        OP_BREAK = 3'd3,
        OP_REG   = 3'd4,
        OP_MEM   = 3'd5,
        OP_STEP  = 3'd6
    } opcode_e;

    // top 3 bits of the register sub-op byte, anything but write reads
    typedef enum logic [2:0] {
        REG_READ  = 3'b010,
        REG_WRITE = 3'b100
    } reg_sub_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BP_WORD,
        ST_REG_SUB,
        ST_REG_WORD,
        ST_MEM_ADDR,
        ST_MEM_WORD
    } parser_state_e;

endpackage

/* common/dbg_cmd_if.sv */
`include "dbg_params.svh"

// decoded commands, one-cycle strobes with operands valid alongside
interface dbg_cmd_if;

    logic                       run_stb;
    logic                       step_stb;
    logic                       bp_load_stb;
    logic                       reg_wr_stb;
    logic                       reg_rd_stb;
    logic                       mem_wr_stb;
    logic                       mem_rd_stb;
    logic [`DBG_XLEN-1:0]       word;
    logic [`DBG_REG_AW-1:0]     reg_addr;
    logic [`DBG_MEM_AW-1:0]     mem_addr;

    modport parser (
        output run_stb, step_stb, bp_load_stb,
        output reg_wr_stb, reg_rd_stb, mem_wr_stb, mem_rd_stb,
        output word, reg_addr, mem_addr
    );

    modport run (
        input run_stb, step_stb, bp_load_stb, word
    );

    modport access (
        input reg_wr_stb, reg_rd_stb, mem_wr_stb, mem_rd_stb,
        input word, reg_addr, mem_addr
    );

endinterface

/* cmd_parser/cmd_parser.sv */
`include "dbg_params.svh"

module cmd_parser (
    input  logic        clk_i,
    input  logic        rst_n,
    input  logic [7:0]  cmd_data_i,
    input  logic        cmd_data_valid_i,
    output logic        proc_reset_o,
    output logic        proc_inst_print_o,
    dbg_cmd_if.parser   cmd
);

    localparam logic [`DBG_CNT_W-1:0] WORD_LAST = `DBG_WORD_BYTES;
    localparam logic [`DBG_CNT_W-1:0] ADDR_LAST = `DBG_ADDR_BYTES;
    localparam int                    MEM_WR_BIT = 8 * `DBG_ADDR_BYTES - 1;

    dbg_pkg::parser_state_e     state;
    dbg_pkg::opcode_e           opcode;
    dbg_pkg::reg_sub_e          reg_sub;

    logic [7:0]                 byte_q;
    logic                       byte_vld_q;
    logic [`DBG_CNT_W-1:0]      byte_cnt;
    logic [`DBG_CNT_W-1:0]      byte_cnt_nxt;
    logic [`DBG_XLEN-1:0]       word_q;
    logic [`DBG_XLEN-1:0]       word_nxt;
    logic                       word_done;
    logic                       addr_done;
    logic                       collecting;

    ////////////////////////////////////////////////////////////////////////
    // byte capture
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            byte_vld_q <= 1'b0;
        end else begin
            byte_vld_q <= cmd_data_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_data_valid_i) begin
            byte_q <= cmd_data_i;
        end
    end

    assign opcode  = dbg_pkg::opcode_e'(byte_q[2:0]);
    assign reg_sub = dbg_pkg::reg_sub_e'(byte_q[7:5]);

    // big-endian shift, newest byte lands in the low lane
    assign word_nxt     = {word_q[`DBG_XLEN-9:0], byte_q};
    assign byte_cnt_nxt = byte_cnt + 1'b1;
    assign word_done    = (byte_cnt_nxt == WORD_LAST);
    assign addr_done    = (byte_cnt_nxt == ADDR_LAST);

    assign collecting = (state == dbg_pkg::ST_BP_WORD)  ||
                        (state == dbg_pkg::ST_REG_WORD) ||
                        (state == dbg_pkg::ST_MEM_ADDR) ||
                        (state == dbg_pkg::ST_MEM_WORD);

    ////////////////////////////////////////////////////////////////////////
    // operands
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (byte_vld_q && collecting) begin
            word_q <= word_nxt;
        end
        if (byte_vld_q && state == dbg_pkg::ST_REG_SUB) begin
            cmd.reg_addr <= byte_q[`DBG_REG_AW-1:0];
        end
        if (byte_vld_q && state == dbg_pkg::ST_MEM_ADDR && addr_done) begin
            cmd.mem_addr <= word_nxt[`DBG_MEM_AW-1:0];
        end
    end

    assign cmd.word = word_q;

    ////////////////////////////////////////////////////////////////////////
    // command FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state             <= dbg_pkg::ST_IDLE;
            byte_cnt          <= '0;
            proc_reset_o      <= 1'b0;
            proc_inst_print_o <= 1'b0;
            cmd.run_stb       <= 1'b0;
            cmd.step_stb      <= 1'b0;
            cmd.bp_load_stb   <= 1'b0;
            cmd.reg_wr_stb    <= 1'b0;
            cmd.reg_rd_stb    <= 1'b0;
            cmd.mem_wr_stb    <= 1'b0;
            cmd.mem_rd_stb    <= 1'b0;
        end else begin
            // every strobe is a single cycle
            proc_reset_o      <= 1'b0;
            proc_inst_print_o <= 1'b0;
            cmd.run_stb       <= 1'b0;
            cmd.step_stb      <= 1'b0;
            cmd.bp_load_stb   <= 1'b0;
            cmd.reg_wr_stb    <= 1'b0;
            cmd.reg_rd_stb    <= 1'b0;
            cmd.mem_wr_stb    <= 1'b0;
            cmd.mem_rd_stb    <= 1'b0;
            if (byte_vld_q) begin
                case (state)
                    dbg_pkg::ST_IDLE: begin
                        byte_cnt <= '0;
                        case (opcode)
                            dbg_pkg::OP_RUN:   cmd.run_stb       <= 1'b1;
                            dbg_pkg::OP_RESET: proc_reset_o      <= 1'b1;
                            dbg_pkg::OP_PRINT: proc_inst_print_o <= 1'b1;
                            dbg_pkg::OP_STEP:  cmd.step_stb      <= 1'b1;
                            dbg_pkg::OP_BREAK: state <= dbg_pkg::ST_BP_WORD;
                            dbg_pkg::OP_REG:   state <= dbg_pkg::ST_REG_SUB;
                            dbg_pkg::OP_MEM:   state <= dbg_pkg::ST_MEM_ADDR;
                            // opcode 7 is dropped silently
                            default:           state <= dbg_pkg::ST_IDLE;
                        endcase
                    end
                    dbg_pkg::ST_REG_SUB: begin
                        if (reg_sub == dbg_pkg::REG_WRITE) begin
                            state <= dbg_pkg::ST_REG_WORD;
                        end else begin
                            cmd.reg_rd_stb <= 1'b1;
                            state          <= dbg_pkg::ST_IDLE;
                        end
                    end
                    dbg_pkg::ST_MEM_ADDR: begin
                        if (addr_done) begin
                            byte_cnt <= '0;
                            if (word_nxt[MEM_WR_BIT]) begin
                                state <= dbg_pkg::ST_MEM_WORD;
                            end else begin
                                cmd.mem_rd_stb <= 1'b1;
                                state          <= dbg_pkg::ST_IDLE;
                            end
                        end else begin
                            byte_cnt <= byte_cnt_nxt;
                        end
                    end
                    dbg_pkg::ST_BP_WORD, dbg_pkg::ST_REG_WORD, dbg_pkg::ST_MEM_WORD: begin
                        if (word_done) begin
                            byte_cnt        <= '0;
                            state           <= dbg_pkg::ST_IDLE;
                            cmd.bp_load_stb <= (state == dbg_pkg::ST_BP_WORD);
                            cmd.reg_wr_stb  <= (state == dbg_pkg::ST_REG_WORD);
                            cmd.mem_wr_stb  <= (state == dbg_pkg::ST_MEM_WORD);
                        end else begin
                            byte_cnt <= byte_cnt_nxt;
                        end
                    end
                    default: begin
                        state <= dbg_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* design/run_ctrl.sv */
`include "dbg_params.svh"

module run_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n,
    input  logic [`DBG_XLEN-1:0]    pc_i,
    input  logic                    pc_ov_i,
    dbg_cmd_if.run                  cmd,
    output logic                    proc_run_en_o
);

    logic [`DBG_XLEN-1:0]   bp_pc;
    logic                   bp_en;
    logic                   bp_hit;
    logic                   run_hold;

    ////////////////////////////////////////////////////////////////////////
    // breakpoint
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            bp_en <= 1'b0;
        end else if (cmd.bp_load_stb) begin
            bp_en <= (cmd.word != `DBG_BP_OFF);
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd.bp_load_stb) begin
            bp_pc <= cmd.word;
        end
    end

    assign bp_hit = bp_en && (pc_i == bp_pc);

    // overflow beats a new run, a new run beats the breakpoint
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            run_hold <= 1'b0;
        end else if (pc_ov_i) begin
            run_hold <= 1'b0;
        end else if (cmd.run_stb) begin
            run_hold <= 1'b1;
        end else if (bp_hit) begin
            run_hold <= 1'b0;
        end
    end

    // a step opens the enable for its one strobe cycle
    assign proc_run_en_o = run_hold | cmd.step_stb;

endmodule

/* design/access_port.sv */
`include "dbg_params.svh"

module access_port (
    input  logic                        clk_i,
    input  logic                        rst_n,
    dbg_cmd_if.access                   cmd,
    output logic                        reg_wren_o,
    output logic [`DBG_REG_AW-1:0]      reg_addr_o,
    output logic [`DBG_XLEN-1:0]        reg_wdata_o,
    output logic                        reg_rdata_tx_o,
    output logic                        mem_wren_o,
    output logic [`DBG_MEM_AW-1:0]      mem_addr_o,
    output logic [`DBG_XLEN-1:0]        mem_wdata_o,
    output logic                        mem_rdata_tx_o
);

    logic [`DBG_REG_AW-1:0]     reg_addr_q;
    logic [`DBG_XLEN-1:0]       reg_wdata_q;
    logic [`DBG_MEM_AW-1:0]     mem_addr_q;
    logic [`DBG_XLEN-1:0]       mem_wdata_q;
    logic                       reg_acc;
    logic                       mem_acc;
    logic                       mem_rd_d1;

    assign reg_acc = cmd.reg_wr_stb | cmd.reg_rd_stb;
    assign mem_acc = cmd.mem_wr_stb | cmd.mem_rd_stb;

    // held copies keep the last access visible between commands
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            reg_addr_q  <= '0;
            reg_wdata_q <= '0;
            mem_addr_q  <= '0;
            mem_wdata_q <= '0;
        end else begin
            if (reg_acc) reg_addr_q  <= cmd.reg_addr;
            if (cmd.reg_wr_stb) reg_wdata_q <= cmd.word;
            if (mem_acc) mem_addr_q  <= cmd.mem_addr;
            if (cmd.mem_wr_stb) mem_wdata_q <= cmd.word;
        end
    end

    // operands pass straight out in the strobe cycle itself
    assign reg_addr_o  = reg_acc ? cmd.reg_addr : reg_addr_q;
    assign reg_wdata_o = cmd.reg_wr_stb ? cmd.word : reg_wdata_q;
    assign mem_addr_o  = mem_acc ? cmd.mem_addr : mem_addr_q;
    assign mem_wdata_o = cmd.mem_wr_stb ? cmd.word : mem_wdata_q;

    assign reg_wren_o = cmd.reg_wr_stb;
    assign mem_wren_o = cmd.mem_wr_stb;

    // memory needs one more cycle of read latency than the register file
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata_tx_o <= 1'b0;
            mem_rd_d1      <= 1'b0;
            mem_rdata_tx_o <= 1'b0;
        end else begin
            reg_rdata_tx_o <= cmd.reg_rd_stb;
            mem_rd_d1      <= cmd.mem_rd_stb;
            mem_rdata_tx_o <= mem_rd_d1;
        end
    end

endmodule

/* design/debug_core.sv */
`include "dbg_params.svh"

module debug_core (
    input  logic                        clk_i,
    input  logic                        rst_n,
    input  logic [7:0]                  cmd_data_i,
    input  logic                        cmd_data_valid_i,
    input  logic [`DBG_XLEN-1:0]        pc_i,
    input  logic                        pc_ov_i,
    output logic                        proc_run_en_o,
    output logic                        proc_reset_o,
    output logic                        proc_inst_print_o,
    output logic                        reg_wren_o,
    output logic [`DBG_REG_AW-1:0]      reg_addr_o,
    output logic [`DBG_XLEN-1:0]        reg_wdata_o,
    output logic                        reg_rdata_tx_o,
    output logic                        mem_wren_o,
    output logic [`DBG_MEM_AW-1:0]      mem_addr_o,
    output logic [`DBG_XLEN-1:0]        mem_wdata_o,
    output logic                        mem_rdata_tx_o
);

    dbg_cmd_if u_cmd_if ();

    cmd_parser u_cmd_parser (
        .clk_i             (clk_i),
        .rst_n             (rst_n),
        .cmd_data_i        (cmd_data_i),
        .cmd_data_valid_i  (cmd_data_valid_i),
        .proc_reset_o      (proc_reset_o),
        .proc_inst_print_o (proc_inst_print_o),
        .cmd               (u_cmd_if.parser)
    );

    run_ctrl u_run_ctrl (
        .clk_i         (clk_i),
        .rst_n         (rst_n),
        .pc_i          (pc_i),
        .pc_ov_i       (pc_ov_i),
        .cmd           (u_cmd_if.run),
        .proc_run_en_o (proc_run_en_o)
    );

    access_port u_access_port (
        .clk_i          (clk_i),
        .rst_n          (rst_n),
        .cmd            (u_cmd_if.access),
        .reg_wren_o     (reg_wren_o),
        .reg_addr_o     (reg_addr_o),
        .reg_wdata_o    (reg_wdata_o),
        .reg_rdata_tx_o (reg_rdata_tx_o),
        .mem_wren_o     (mem_wren_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_rdata_tx_o (mem_rdata_tx_o)
    );

endmodule

/* testbench/dbg_checker.sv */
`include "dbg_params.svh"

// watches the debug core ports and compares them with a cycle model of the command rules
module dbg_checker (
    input  logic                        clk_i,
    input  logic                        rst_n,
    input  logic [7:0]                  cmd_data_i,
    input  logic                        cmd_data_valid_i,
    input  logic [`DBG_XLEN-1:0]        pc_i,
    input  logic                        pc_ov_i,
    input  logic                        proc_run_en_i,
    input  logic                        proc_reset_i,
    input  logic                        proc_inst_print_i,
    input  logic                        reg_wren_i,
    input  logic [`DBG_REG_AW-1:0]      reg_addr_i,
    input  logic [`DBG_XLEN-1:0]        reg_wdata_i,
    input  logic                        reg_rdata_tx_i,
    input  logic                        mem_wren_i,
    input  logic [`DBG_MEM_AW-1:0]      mem_addr_i,
    input  logic [`DBG_XLEN-1:0]        mem_wdata_i,
    input  logic                        mem_rdata_tx_i,
    output int                          err_cnt_o
);

    typedef enum logic [3:0] {
        EV_WAIT, EV_IGNORE, EV_RUN, EV_RESET, EV_PRINT, EV_STEP,
        EV_BREAK, EV_REG_WR, EV_REG_RD, EV_MEM_WR, EV_MEM_RD
    } event_e;

    // at is the edge that samples the effect
    // stb_at is the edge of the internal strobe
    typedef struct packed {
        event_e                 kind;
        int                     offset;
        logic [`DBG_XLEN-1:0]   addr;
        logic [`DBG_XLEN-1:0]   data;
        int                     at;
        int                     stb_at;
    } expect_t;

    expect_t                    pend [16];
    expect_t                    ev;
    logic [7:0]                 seq [$];
    int                         edge_n;
    int                         nxt;
    int                         errors = 0;
    logic                       hold;
    logic                       bp_en;
    logic [`DBG_XLEN-1:0]       bp_pc;
    logic [`DBG_REG_AW-1:0]     exp_reg_addr;
    logic [`DBG_XLEN-1:0]       exp_reg_wdata;
    logic [`DBG_MEM_AW-1:0]     exp_mem_addr;
    logic [`DBG_XLEN-1:0]       exp_mem_wdata;

    assign err_cnt_o = errors;

    ////////////////////////////////////////////////////////////////////////////
    // reference model of one command
    ////////////////////////////////////////////////////////////////////////////

    // gives EV_WAIT until the bytes so far make up a whole command
    function automatic expect_t predict_cmd(input logic [7:0] b[$]);
        expect_t        res;
        int             n;
        logic [15:0]    af;
        n          = b.size();
        res        = '0;
        res.kind   = EV_WAIT;
        res.offset = 2;
        case (b[0][2:0])
            dbg_pkg::OP_RUN: begin
                res.kind   = EV_RUN;
                res.offset = 3;
            end
            dbg_pkg::OP_RESET: res.kind = EV_RESET;
            dbg_pkg::OP_PRINT: res.kind = EV_PRINT;
            dbg_pkg::OP_STEP:  res.kind = EV_STEP;
            dbg_pkg::OP_BREAK: begin
                if (n == 1 + `DBG_WORD_BYTES) res.kind = EV_BREAK;
            end
            dbg_pkg::OP_REG: begin
                if (n >= 2) begin
                    res.addr = 32'(b[1][4:0]);
                    if (b[1][7:5] != dbg_pkg::REG_WRITE) begin
                        res.kind   = EV_REG_RD;
                        res.offset = 3;
                    end else if (n == 2 + `DBG_WORD_BYTES) begin
                        res.kind = EV_REG_WR;
                    end
                end
            end
            dbg_pkg::OP_MEM: begin
                if (n >= 1 + `DBG_ADDR_BYTES) begin
                    af       = {b[1], b[2]};
                    res.addr = 32'(af[14:0]);
                    // top bit of the address field selects a write
                    if (!af[15]) begin
                        res.kind   = EV_MEM_RD;
                        res.offset = 4;
                    end else if (n == 1 + `DBG_ADDR_BYTES + `DBG_WORD_BYTES) begin
                        res.kind = EV_MEM_WR;
                    end
                end
            end
            default: res.kind = EV_IGNORE;
        endcase
        // data words arrive msb first and end the command
        if (n >= 4) res.data = {b[n-4], b[n-3], b[n-2], b[n-1]};
        return res;
    endfunction

    // byte capture, run hold and breakpoint on the rising edge
    always @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            edge_n    = 0;
            hold      = 1'b0;
            bp_en     = 1'b0;
            bp_pc     = '0;
            seq.delete();
            for (int k = 0; k < 16; k++) pend[k] = '0;
        end else begin
            edge_n = edge_n + 1;
            // overflow first, then a new run, then the breakpoint
            if (pc_ov_i) begin
                hold = 1'b0;
            end else if (pend[EV_RUN].at == edge_n + 1) begin
                hold = 1'b1;
            end else if (bp_en && pc_i == bp_pc) begin
                hold = 1'b0;
            end
            if (pend[EV_BREAK].at == edge_n) begin
                bp_en = (pend[EV_BREAK].data != `DBG_BP_OFF);
                bp_pc = pend[EV_BREAK].data;
            end
            if (cmd_data_valid_i) begin
                seq.push_back(cmd_data_i);
                ev = predict_cmd(seq);
                if (ev.kind != EV_WAIT) begin
                    seq.delete();
                    ev.at     = edge_n + ev.offset;
                    ev.stb_at = edge_n + 2;
                    if (ev.kind != EV_IGNORE) pend[ev.kind] = ev;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_pulse(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            if (exp) begin
                $display("missing pulse on %s at edge %0d", name, nxt);
            end else begin
                $display("unexpected pulse on %s at edge %0d", name, nxt);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [`DBG_XLEN-1:0] got,
                               input logic [`DBG_XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h at edge %0d", name, exp, got, nxt);
        end
    endtask

    always @(negedge clk_i) begin
        nxt = edge_n + 1;
        if (!rst_n) begin
            exp_reg_addr  = '0;
            exp_reg_wdata = '0;
            exp_mem_addr  = '0;
            exp_mem_wdata = '0;
        end else begin
            // held operands switch in the strobe cycle of an access
            if (pend[EV_REG_WR].stb_at == nxt) begin
                exp_reg_addr  = pend[EV_REG_WR].addr[`DBG_REG_AW-1:0];
                exp_reg_wdata = pend[EV_REG_WR].data;
            end
            if (pend[EV_REG_RD].stb_at == nxt) begin
                exp_reg_addr = pend[EV_REG_RD].addr[`DBG_REG_AW-1:0];
            end
            if (pend[EV_MEM_WR].stb_at == nxt) begin
                exp_mem_addr  = pend[EV_MEM_WR].addr[`DBG_MEM_AW-1:0];
                exp_mem_wdata = pend[EV_MEM_WR].data;
            end
            if (pend[EV_MEM_RD].stb_at == nxt) begin
                exp_mem_addr = pend[EV_MEM_RD].addr[`DBG_MEM_AW-1:0];
            end
        end
        check_pulse("proc_reset_o", proc_reset_i, pend[EV_RESET].at == nxt);
        check_pulse("proc_inst_print_o", proc_inst_print_i, pend[EV_PRINT].at == nxt);
        check_pulse("reg_wren_o", reg_wren_i, pend[EV_REG_WR].at == nxt);
        check_pulse("reg_rdata_tx_o", reg_rdata_tx_i, pend[EV_REG_RD].at == nxt);
        check_pulse("mem_wren_o", mem_wren_i, pend[EV_MEM_WR].at == nxt);
        check_pulse("mem_rdata_tx_o", mem_rdata_tx_i, pend[EV_MEM_RD].at == nxt);
        check_value("proc_run_en_o", proc_run_en_i, hold | (pend[EV_STEP].at == nxt));
        check_value("reg_addr_o", reg_addr_i, exp_reg_addr);
        check_value("reg_wdata_o", reg_wdata_i, exp_reg_wdata);
        check_value("mem_addr_o", mem_addr_i, exp_mem_addr);
        check_value("mem_wdata_o", mem_wdata_i, exp_mem_wdata);
    end

endmodule

/* testbench/tb_debug_core.sv */
`include "dbg_params.svh"

module tb_debug_core;

    localparam int NUM_RAND   = 60;
    localparam int NUM_DIRECT = 16;
    // longest command is 7 bytes and a byte slot is at most 10 cycles
    localparam int MAX_CYCLES = (NUM_RAND + NUM_DIRECT) * 7 * 10 + 500;
    localparam logic [`DBG_XLEN-1:0] PC_IDLE = 32'h0000_0040;
    localparam logic [`DBG_XLEN-1:0] PC_BP   = 32'h0000_1230;

    logic                       clk_i;
    logic                       rst_n;
    logic [7:0]                 cmd_data_i;
    logic                       cmd_data_valid_i;
    logic [`DBG_XLEN-1:0]       pc_i;
    logic                       pc_ov_i;
    logic                       proc_run_en_o;
    logic                       proc_reset_o;
    logic                       proc_inst_print_o;
    logic                       reg_wren_o;
    logic [`DBG_REG_AW-1:0]     reg_addr_o;
    logic [`DBG_XLEN-1:0]       reg_wdata_o;
    logic                       reg_rdata_tx_o;
    logic                       mem_wren_o;
    logic [`DBG_MEM_AW-1:0]     mem_addr_o;
    logic [`DBG_XLEN-1:0]       mem_wdata_o;
    logic                       mem_rdata_tx_o;
    int                         chk_errs;
    int                         tb_errs = 0;
    int                         cycles = 0;

    debug_core u_dut (
        .clk_i (clk_i), .rst_n (rst_n),
        .cmd_data_i (cmd_data_i), .cmd_data_valid_i (cmd_data_valid_i),
        .pc_i (pc_i), .pc_ov_i (pc_ov_i),
        .proc_run_en_o (proc_run_en_o), .proc_reset_o (proc_reset_o),
        .proc_inst_print_o (proc_inst_print_o),
        .reg_wren_o (reg_wren_o), .reg_addr_o (reg_addr_o),
        .reg_wdata_o (reg_wdata_o), .reg_rdata_tx_o (reg_rdata_tx_o),
        .mem_wren_o (mem_wren_o), .mem_addr_o (mem_addr_o),
        .mem_wdata_o (mem_wdata_o), .mem_rdata_tx_o (mem_rdata_tx_o)
    );

    dbg_checker u_chk (
        .clk_i (clk_i), .rst_n (rst_n),
        .cmd_data_i (cmd_data_i), .cmd_data_valid_i (cmd_data_valid_i),
        .pc_i (pc_i), .pc_ov_i (pc_ov_i),
        .proc_run_en_i (proc_run_en_o), .proc_reset_i (proc_reset_o),
        .proc_inst_print_i (proc_inst_print_o),
        .reg_wren_i (reg_wren_o), .reg_addr_i (reg_addr_o),
        .reg_wdata_i (reg_wdata_o), .reg_rdata_tx_i (reg_rdata_tx_o),
        .mem_wren_i (mem_wren_o), .mem_addr_i (mem_addr_o),
        .mem_wdata_i (mem_wdata_o), .mem_rdata_tx_i (mem_rdata_tx_o),
        .err_cnt_o (chk_errs)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, errors: checker %0d, testbench %0d",
                     cycles, chk_errs, tb_errs);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // byte level stimulus that starts and ends just after a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap              = 6 + int'($urandom % 4);
        cmd_data_i       = b;
        cmd_data_valid_i = 1'b1;
        @(negedge clk_i);
        cmd_data_valid_i = 1'b0;
        cmd_data_i       = 8'($urandom);
        repeat (gap - 1) @(negedge clk_i);
    endtask

    task automatic send_word(input logic [`DBG_XLEN-1:0] w);
        for (int i = `DBG_WORD_BYTES - 1; i >= 0; i--) send_byte(w[8*i +: 8]);
    endtask

    // upper bits of an opcode byte are don't care
    task automatic issue_simple(input logic [2:0] op);
        send_byte({5'($urandom), op});
    endtask

    task automatic issue_break(input logic [`DBG_XLEN-1:0] w);
        issue_simple(dbg_pkg::OP_BREAK);
        send_word(w);
    endtask

    task automatic issue_reg(input logic wr, input logic [4:0] a, input logic [31:0] w);
        logic [2:0] sub;
        sub = 3'($urandom);
        if (wr) begin
            sub = dbg_pkg::REG_WRITE;
        end else if (sub == dbg_pkg::REG_WRITE) begin
            sub = 3'b000;
        end
        issue_simple(dbg_pkg::OP_REG);
        send_byte({sub, a});
        if (wr) send_word(w);
    endtask

    task automatic issue_mem(input logic wr, input logic [14:0] a, input logic [31:0] w);
        issue_simple(dbg_pkg::OP_MEM);
        send_byte({wr, a[14:8]});
        send_byte(a[7:0]);
        if (wr) send_word(w);
    endtask

    task automatic wait_run_level(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (proc_run_en_o !== level && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (proc_run_en_o !== level) begin
            tb_errs++;
            $display("%s", what);
        end
    endtask

    // run byte whose internal strobe meets pc_ov_i on the same edge
    task automatic run_into_overflow();
        cmd_data_i       = {5'($urandom), dbg_pkg::OP_RUN};
        cmd_data_valid_i = 1'b1;
        @(negedge clk_i);
        cmd_data_valid_i = 1'b0;
        @(negedge clk_i);
        pc_ov_i = 1'b1;
        @(negedge clk_i);
        pc_ov_i = 1'b0;
        repeat (6) @(negedge clk_i);
        if (proc_run_en_o !== 1'b0) begin
            tb_errs++;
            $display("run command won over pc_ov_i in the same cycle");
        end
    endtask

    task automatic pulse_overflow();
        pc_ov_i = 1'b1;
        @(negedge clk_i);
        pc_ov_i = 1'b0;
        wait_run_level(1'b0, 3, "pc_ov_i did not stop the run");
    endtask

    initial begin
        int pick;
        void'($urandom(32'heb2c_c738));
        rst_n            = 1'b0;
        cmd_data_i       = 8'h00;
        cmd_data_valid_i = 1'b0;
        pc_i             = PC_IDLE;
        pc_ov_i          = 1'b0;
        repeat (10) @(negedge clk_i);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_i);

        // pulses, step, run until overflow
        issue_simple(dbg_pkg::OP_RESET);
        issue_simple(dbg_pkg::OP_PRINT);
        issue_simple(dbg_pkg::OP_STEP);
        issue_simple(dbg_pkg::OP_RUN);
        wait_run_level(1'b1, 4, "run command did not start the processor");
        pulse_overflow();

        // register write and read
        issue_reg(1'b1, 5'h0a, 32'h1234_5678);
        issue_reg(1'b0, 5'h1f, 32'h0);

        // breakpoint hit, then the same pc with the breakpoint off
        issue_simple(dbg_pkg::OP_RUN);
        issue_break(PC_BP);
        pc_i = PC_BP;
        wait_run_level(1'b0, 3, "breakpoint did not stop the run");
        pc_i = PC_IDLE;
        issue_simple(dbg_pkg::OP_RUN);
        issue_break(`DBG_BP_OFF);
        pc_i = PC_BP;
        repeat (4) @(negedge clk_i);
        // a pc equal to the loaded off pattern must not count as a hit
        pc_i = `DBG_BP_OFF;
        repeat (4) @(negedge clk_i);
        if (proc_run_en_o !== 1'b1) begin
            tb_errs++;
            $display("run stopped although the breakpoint is off");
        end
        pc_i = PC_IDLE;

        // memory write and read
        issue_mem(1'b1, 15'h1abc, 32'hdead_beef);
        issue_mem(1'b0, 15'h0123, 32'h0);

        // overflow against a new run and an unused opcode while stopped
        run_into_overflow();
        issue_simple(3'd7);

        for (int i = 0; i < NUM_RAND; i++) begin
            pick = int'($urandom % 8);
            case (pick)
                3: issue_break($urandom);
                4: issue_reg(1'($urandom), 5'($urandom), $urandom);
                5: issue_mem(1'($urandom), 15'($urandom), $urandom);
                default: issue_simple(3'(pick));
            endcase
        end

        repeat (10) @(negedge clk_i);
        $display("errors: checker %0d, testbench %0d", chk_errs, tb_errs);
        if (chk_errs == 0 && tb_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/dbg_pkg.sv
common/dbg_cmd_if.sv
cmd_parser/cmd_parser.sv
design/run_ctrl.sv
design/access_port.sv
design/debug_core.sv
testbench/dbg_checker.sv
testbench/tb_debug_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the debug core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_debug_core \
    -Mdir "$BUILD_DIR" -o sim_debug_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_debug_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
exit 1
